// ==== Makefile ====
# Verilator flow for the single-precision sqrt unit
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_fp_sqrt
RTL_TOP   ?= fp_sqrt
FILELIST  ?= fp_sqrt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Status comes from the search, not from the simulator
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== fp_sqrt.f ====
+incdir+include
rtl/fp_sqrt_pkg.sv
rtl/sqrt_ctrl.sv
rtl/fp_classify.sv
rtl/sqrt_recurrence.sv
rtl/sqrt_round.sv
rtl/fp_sqrt.sv
testbench/tb_fp_sqrt.sv

// ==== rtl/fp_classify.sv ====
// ==================================================
// Operand capture and special-value classification
// ==================================================
`timescale 1ns/100ps

module fp_classify (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  capture_en,
  input  fp_sqrt_pkg::fp_word_t                 operand,
  input  fp_sqrt_pkg::round_mode_t              rounding_mode,
  output logic                                  sign,
  output logic [fp_sqrt_pkg::EXP_WIDTH-1:0]     exp_field,
  output logic [fp_sqrt_pkg::MAN_WIDTH:0]       significand,
  output fp_sqrt_pkg::special_t                 special_kind,
  output logic                                  invalid,      // Sqrt of negative
  output fp_sqrt_pkg::round_mode_t              mode
);
  import fp_sqrt_pkg::*;

  logic [EXP_WIDTH-1:0] in_exp;
  logic [MAN_WIDTH-1:0] in_frac;
  logic                 exp_ones;
  logic                 exp_zero;  // Zero or subnormal exponent

  assign in_exp   = operand[MAN_WIDTH +: EXP_WIDTH];
  assign in_frac  = operand[MAN_WIDTH-1:0];
  assign exp_ones = &in_exp;
  assign exp_zero = ~|in_exp;

  // Operand fields
  always_ff @(posedge clk) begin
    if (capture_en) begin
      sign        <= operand[31];
      exp_field   <= in_exp;
      significand <= {1'b1, in_frac};  // Hidden one
    end
  end

  // Classification in priority order NaN, negative, +inf, zero
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      special_kind <= SP_NONE;
      invalid      <= 1'b0;
      mode         <= RNE;
    end else if (capture_en) begin
      mode    <= rounding_mode;
      invalid <= 1'b0;
      if (exp_ones && (in_frac != '0)) begin
        special_kind <= SP_QNAN;                 // Any NaN raises no flag
      end else if (operand[31] && !exp_zero) begin
        special_kind <= SP_QNAN;                 // Negative non-zero including -inf
        invalid      <= 1'b1;
      end else if (exp_ones) begin
        special_kind <= SP_INF;
      end else if (exp_zero) begin
        special_kind <= SP_ZERO;                 // Sign kept
      end else begin
        special_kind <= SP_NONE;
      end
    end
  end

endmodule

// ==== rtl/fp_sqrt.sv ====
// ==================================================
// Single-precision square root unit, top level
// Wires sequencer, operand classifier, recurrence
// engine and rounding stage together
// ==================================================
`timescale 1ns/100ps

module fp_sqrt (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     start,          // Accepted only while not busy
  input  fp_sqrt_pkg::round_mode_t rounding_mode,  // Captured with start
  input  fp_sqrt_pkg::fp_word_t    operand,        // Captured with start
  output logic                     busy,
  output logic                     done,           // One-cycle pulse
  output fp_sqrt_pkg::fp_word_t    result,         // Held until next start
  output logic                     flag_nv,
  output logic                     flag_nx
);
  import fp_sqrt_pkg::*;

  // Sequencer strobes
  logic capture_en;
  logic load_en;
  logic step_en;
  logic finish_en;

  // Captured operand fields
  logic                 sign;
  logic [EXP_WIDTH-1:0] exp_field;
  logic [MAN_WIDTH:0]   significand;  // Hidden one restored
  special_t             special_kind;
  logic                 invalid;
  round_mode_t          mode;

  // Recurrence outputs
  logic [ROOT_WIDTH-1:0] root;
  logic                  rem_nonzero;
  logic [EXP_WIDTH-1:0]  res_exp;

  sqrt_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .special_kind (special_kind),
    .capture_en   (capture_en),
    .load_en      (load_en),
    .step_en      (step_en),
    .finish_en    (finish_en),
    .busy         (busy),
    .done         (done)
  );

  fp_classify u_classify (
    .clk           (clk),
    .reset_n       (reset_n),
    .capture_en    (capture_en),
    .operand       (operand),
    .rounding_mode (rounding_mode),
    .sign          (sign),
    .exp_field     (exp_field),
    .significand   (significand),
    .special_kind  (special_kind),
    .invalid       (invalid),
    .mode          (mode)
  );

  sqrt_recurrence u_recurrence (
    .clk         (clk),
    .reset_n     (reset_n),
    .load_en     (load_en),
    .step_en     (step_en),
    .significand (significand),
    .exp_field   (exp_field),
    .root        (root),
    .rem_nonzero (rem_nonzero),
    .res_exp     (res_exp)
  );

  sqrt_round u_round (
    .clk          (clk),
    .reset_n      (reset_n),
    .finish_en    (finish_en),
    .root         (root),
    .rem_nonzero  (rem_nonzero),
    .res_exp      (res_exp),
    .special_kind (special_kind),
    .sign         (sign),
    .invalid      (invalid),
    .mode         (mode),
    .result       (result),
    .flag_nv      (flag_nv),
    .flag_nx      (flag_nx)
  );

endmodule

// ==== rtl/fp_sqrt_pkg.sv ====
// ==================================================
// Shared definitions for the single-precision sqrt
// Format widths, recurrence sizes, enum types and
// the canonical NaN constant
// ==================================================

package fp_sqrt_pkg;

  // ==================================================
  // Format constants
  // ==================================================
  localparam int EXP_WIDTH = 8;    // Exponent field
  localparam int MAN_WIDTH = 23;   // Stored fraction
  localparam int BIAS      = 127;  // Exponent bias

  // Recurrence sizing
  localparam int ROOT_WIDTH = 26;              // 24-bit significand + guard + round
  localparam int REM_WIDTH  = ROOT_WIDTH + 2;  // Partial remainder
  localparam int RAD_WIDTH  = 2 * ROOT_WIDTH;  // Two radicand bits per step
  localparam int CNT_WIDTH  = 5;               // Holds ROOT_WIDTH

  // Packed single-precision word
  typedef logic [31:0] fp_word_t;

  // IEEE 754 rounding modes, other codes act as RTZ
  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,  // Toward zero
    RDN = 3'd2,  // Toward -inf
    RUP = 3'd3,  // Toward +inf
    RMM = 3'd4   // Nearest, ties away
  } round_mode_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    DISPATCH,
    ITERATE,
    FINISH
  } ctrl_state_t;

  // Kind of special result picked at classification
  typedef enum logic [1:0] {
    SP_NONE,  // Normal operand, run the recurrence
    SP_QNAN,
    SP_INF,
    SP_ZERO
  } special_t;

  // Canonical quiet NaN
  localparam fp_word_t CANON_NAN = 32'h7FC0_0000;

endpackage

// ==== rtl/sqrt_ctrl.sv ====
// ==================================================
// Sqrt operation sequencer
// State machine, iteration counter, busy and done
// ==================================================
`timescale 1ns/100ps

module sqrt_ctrl (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  fp_sqrt_pkg::special_t special_kind,  // Valid from DISPATCH on
  output logic                  capture_en,    // Latch operand and mode
  output logic                  load_en,       // Init recurrence
  output logic                  step_en,       // One root bit
  output logic                  finish_en,     // Register result and flags
  output logic                  busy,
  output logic                  done
);
  import fp_sqrt_pkg::*;

  ctrl_state_t          state;
  ctrl_state_t          next_state;
  logic [CNT_WIDTH-1:0] count;  // Steps left
  logic                 last_step;

  assign last_step = (count == CNT_WIDTH'(1));

  // Strobes decoded from the current state
  assign capture_en = start && (state == IDLE);  // start ignored while busy
  assign load_en    = (state == DISPATCH) && (special_kind == SP_NONE);
  assign step_en    = (state == ITERATE);
  assign finish_en  = (state == FINISH);

  // ==================================================
  // Next state
  // ==================================================
  always_comb begin
    next_state = state;
    case (state)
      IDLE:     if (start) next_state = DISPATCH;
      DISPATCH: next_state = (special_kind == SP_NONE) ? ITERATE : FINISH;  // Short path
      ITERATE:  if (last_step) next_state = FINISH;
      FINISH:   next_state = IDLE;
      default:  next_state = IDLE;
    endcase
  end

  // ==================================================
  // State, counter and registered status
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
      count <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      busy  <= (next_state != IDLE);  // High from DISPATCH through FINISH
      done  <= (state == FINISH);     // Pulse after the finish edge
      if (load_en) begin
        count <= CNT_WIDTH'(ROOT_WIDTH);
      end else if (step_en) begin
        count <= count - CNT_WIDTH'(1);
      end
    end
  end

endmodule

// ==== rtl/sqrt_recurrence.sv ====
// ==================================================
// Restoring digit recurrence for the root
// Two radicand bits in, one root bit out per step
// ==================================================
`timescale 1ns/100ps

module sqrt_recurrence (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                load_en,
  input  logic                                step_en,
  input  logic [fp_sqrt_pkg::MAN_WIDTH:0]     significand,
  input  logic [fp_sqrt_pkg::EXP_WIDTH-1:0]   exp_field,
  output logic [fp_sqrt_pkg::ROOT_WIDTH-1:0]  root,
  output logic                                rem_nonzero,  // Sticky source
  output logic [fp_sqrt_pkg::EXP_WIDTH-1:0]   res_exp
);
  import fp_sqrt_pkg::*;

  logic signed [EXP_WIDTH+1:0] exp_unb;   // Unbiased exponent e
  logic signed [EXP_WIDTH+1:0] exp_adj;   // Forced even
  logic                        exp_odd;
  logic [RAD_WIDTH-1:0]        rad_init;
  logic [RAD_WIDTH-1:0]        radicand;
  logic [REM_WIDTH-1:0]        remainder;
  logic [REM_WIDTH-1:0]        ac;        // Remainder with next two bits
  logic [REM_WIDTH:0]          trial;     // Extra bit is the borrow
  logic                        accept;

  // ==================================================
  // Exponent halving and radicand alignment
  // ==================================================
  assign exp_unb = signed'({2'b00, exp_field}) - (EXP_WIDTH+2)'(BIAS);
  assign exp_odd = exp_unb[0];
  assign exp_adj = exp_unb - (EXP_WIDTH+2)'(exp_odd);

  // Significand scaled by 2^27, one more for odd e
  assign rad_init = exp_odd ? {significand, {(RAD_WIDTH-MAN_WIDTH-1){1'b0}}}
                            : {1'b0, significand, {(RAD_WIDTH-MAN_WIDTH-2){1'b0}}};

  // Trial subtraction of 4*root + 1
  assign ac     = {remainder[REM_WIDTH-3:0], radicand[RAD_WIDTH-1 -: 2]};
  assign trial  = {1'b0, ac} - {1'b0, root, 2'b01};
  assign accept = ~trial[REM_WIDTH];  // No borrow, difference non-negative

  assign rem_nonzero = |remainder;

  // Radicand and exponent are payload
  always_ff @(posedge clk) begin
    if (load_en) begin
      radicand <= rad_init;
      res_exp  <= EXP_WIDTH'((exp_adj >>> 1) + BIAS);
    end else if (step_en) begin
      radicand <= radicand << 2;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      root      <= '0;
      remainder <= '0;
    end else if (load_en) begin
      root      <= '0;
      remainder <= '0;
    end else if (step_en) begin
      root      <= {root[ROOT_WIDTH-2:0], accept};           // New root bit
      remainder <= accept ? trial[REM_WIDTH-1:0] : ac;       // Restore on reject
    end
  end

endmodule

// ==== rtl/sqrt_round.sv ====
// ==================================================
// Rounding, packing, special results and flags
// ==================================================
`timescale 1ns/100ps

module sqrt_round (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                finish_en,
  input  logic [fp_sqrt_pkg::ROOT_WIDTH-1:0]  root,
  input  logic                                rem_nonzero,
  input  logic [fp_sqrt_pkg::EXP_WIDTH-1:0]   res_exp,
  input  fp_sqrt_pkg::special_t               special_kind,
  input  logic                                sign,
  input  logic                                invalid,
  input  fp_sqrt_pkg::round_mode_t            mode,
  output fp_sqrt_pkg::fp_word_t               result,
  output logic                                flag_nv,
  output logic                                flag_nx
);
  import fp_sqrt_pkg::*;

  logic                           guard;
  logic                           round_bit;
  logic                           sticky;
  logic                           tie_bit;   // LSB of kept fraction
  logic                           round_up;
  logic [EXP_WIDTH+MAN_WIDTH-1:0] mag;       // Exponent and fraction

  assign guard     = root[1];
  assign round_bit = root[0];
  assign sticky    = rem_nonzero;
  assign tie_bit   = root[2];

  // Root is positive, so RDN truncates like RTZ
  always_comb begin
    case (mode)
      RNE:     round_up = guard && (round_bit || sticky || tie_bit);
      RUP:     round_up = guard || round_bit || sticky;
      RMM:     round_up = guard;
      RTZ:     round_up = 1'b0;
      RDN:     round_up = 1'b0;
      default: round_up = 1'b0;  // Undefined codes truncate
    endcase
  end

  // Leading one at root[25] is dropped, carry rolls into exponent
  assign mag = {res_exp, root[ROOT_WIDTH-2:2]} + (EXP_WIDTH+MAN_WIDTH)'(round_up);

  // ==================================================
  // Output registers, held until the next finish
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_nx <= 1'b0;
    end else if (finish_en) begin
      flag_nv <= invalid;
      flag_nx <= 1'b0;
      case (special_kind)
        SP_QNAN: result <= CANON_NAN;
        SP_INF:  result <= {1'b0, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};  // +inf
        SP_ZERO: result <= {sign, {(EXP_WIDTH+MAN_WIDTH){1'b0}}};         // Signed zero
        default: begin
          result  <= {1'b0, mag};
          flag_nx <= guard || round_bit || sticky;
        end
      endcase
    end
  end

endmodule

// ==== include/sqrt_ref.svh ====
// ==================================================
// Reference model for the single-precision sqrt
// Expected result, invalid flag and inexact flag
// ==================================================
`ifndef SQRT_REF_SVH
`define SQRT_REF_SVH

// Integer root of the scaled significand found bit by bit with squares
function automatic fp_word_t expected_sqrt(input fp_word_t op, input round_mode_t rm,
                                           output logic nv, output logic nx);
  logic [7:0]  ef;
  logic [22:0] fr;
  int          e;     // Unbiased exponent
  logic [63:0] rad;   // Significand scaled by 2^27 or 2^28
  logic [63:0] r;     // floor(sqrt(rad)), 26 bits
  logic [63:0] cand;
  logic        g;
  logic        rb;
  logic        st;
  logic        up;
  logic [7:0]  rexp;
  logic [30:0] mag;
  ef = op[30:23];
  fr = op[22:0];
  nv = 1'b0;
  nx = 1'b0;
  // Special values in priority order
  if (ef == 8'hFF && fr != 23'd0) begin
    return 32'h7FC0_0000;  // Any NaN, no flag
  end
  if (op[31] && ef != 8'h00) begin
    nv = 1'b1;             // Negative non-zero, -inf too
    return 32'h7FC0_0000;
  end
  if (ef == 8'hFF) begin
    return 32'h7F80_0000;
  end
  if (ef == 8'h00) begin
    return {op[31], 31'd0};  // Zero or flushed subnormal, sign kept
  end
  e = int'(ef) - BIAS;
  if (e % 2 != 0) begin
    rad = 64'({1'b1, fr}) << 28;  // Odd exponent, radicand doubled
    e   = e - 1;
  end else begin
    rad = 64'({1'b1, fr}) << 27;
  end
  rexp = 8'(e / 2 + BIAS);
  r = 64'd0;
  for (int b = 25; b >= 0; b--) begin
    cand = r | (64'd1 << b);
    if (cand * cand <= rad) begin
      r = cand;  // Keep bit while square fits
    end
  end
  g  = r[1];
  rb = r[0];
  st = (r * r != rad);  // Root not exact
  case (rm)
    RNE:     up = g && (rb || st || r[2]);
    RUP:     up = g || rb || st;
    RMM:     up = g;
    default: up = 1'b0;  // RTZ, RDN and undefined codes
  endcase
  mag = {rexp, r[24:2]} + 31'(up);
  nx  = g || rb || st;
  return {1'b0, mag};
endfunction

`endif

// ==== testbench/tb_fp_sqrt.sv ====
// ==================================================
// Testbench for the single-precision sqrt unit
// Reset, exact, special, random and protocol tests
// ==================================================
`timescale 1ns/100ps

module tb_fp_sqrt;
  import fp_sqrt_pkg::*;

  `include "sqrt_ref.svh"

  localparam int DONE_TIMEOUT  = 100;  // Cycles from accept to done
  localparam int IDLE_TIMEOUT  = 100;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int RANDOM_OPS    = 40;   // Per mode code

  logic        clk;
  logic        reset_n;
  logic        start;
  round_mode_t rounding_mode;
  fp_word_t    operand;
  logic        busy;
  logic        done;
  fp_word_t    result;
  logic        flag_nv;
  logic        flag_nx;

  integer seed;
  longint cycle;      // Rising edges seen so far
  int     checks;
  int     errors;
  int     test_base;  // Error count when the test began

  // Pending operations queued oldest first
  fp_word_t res_q[$];
  logic     nv_q[$];
  logic     nx_q[$];
  int       lat_q[$];
  longint   acc_q[$];   // Cycle of the accepting edge
  string    what_q[$];

  fp_sqrt dut0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .rounding_mode (rounding_mode),
    .operand       (operand),
    .busy          (busy),
    .done          (done),
    .result        (result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

  always #5 clk = ~clk;  // 10 ns period

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_result(input fp_word_t got, input fp_word_t want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s result %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flags(input logic got_nv, input logic got_nx,
                             input logic want_nv, input logic want_nx, input string what);
    checks++;
    if ({got_nv, got_nx} !== {want_nv, want_nx}) begin
      errors++;
      $display("Fail at %0t: %s flags nv=%b nx=%b, expected nv=%b nx=%b",
               $time, what, got_nv, got_nx, want_nv, want_nx);
    end
  endtask

  task automatic check_latency(input int got, input int want, input string what);
    checks++;
    if (got != want) begin
      errors++;
      $display("Fail at %0t: %s latency %0d edges, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_status(input logic got_busy, input logic got_done,
                              input logic want_busy, input logic want_done, input string what);
    checks++;
    if ({got_busy, got_done} !== {want_busy, want_done}) begin
      errors++;
      $display("Fail at %0t: %s busy=%b done=%b, expected busy=%b done=%b",
               $time, what, got_busy, got_done, want_busy, want_done);
    end
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    while (busy && n < IDLE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("Timeout: DUT still busy after %0d cycles at %0t", IDLE_TIMEOUT, $time);
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (res_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (res_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d operations still pending at %0t", res_q.size(), $time);
    end
  endtask

  task automatic finish_test(input string name);
    wait_drained();
    $display("Test %s finished at %0t with %0d errors", name, $time, errors - test_base);
    test_base = errors;
  endtask

  // Launch one operation and queue what the compare process should see
  task automatic issue_op(input fp_word_t op, input round_mode_t rm,
                          input fp_word_t want, input logic want_nv, input logic want_nx);
    logic [7:0] ef;
    ef = op[30:23];
    wait_idle();
    start         <= 1'b1;
    operand       <= op;
    rounding_mode <= rm;
    @(posedge clk);        // Accepting edge
    start         <= 1'b0;
    operand       <= ~op;  // Source need not hold it
    res_q.push_back(want);
    nv_q.push_back(want_nv);
    nx_q.push_back(want_nx);
    lat_q.push_back((ef == 8'h00 || ef == 8'hFF || op[31]) ? 2 : 28);  // Short path for specials
    acc_q.push_back(cycle);
    what_q.push_back($sformatf("sqrt(%h) mode %0d", op, rm));
  endtask

  task automatic issue_ref(input fp_word_t op, input round_mode_t rm);
    fp_word_t want;
    logic     nv;
    logic     nx;
    want = expected_sqrt(op, rm, nv, nx);
    issue_op(op, rm, want, nv, nx);
  endtask

  // ==================================================
  // Compare process
  // ==================================================
  initial begin : compare_results
    int     waited;
    int     lat;
    longint acc;
    string  what;
    forever begin
      @(posedge clk);
      if (res_q.size() != 0) begin
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
          @(posedge clk);
          waited++;
        end
        acc  = acc_q.pop_front();
        what = what_q.pop_front();
        if (!done) begin
          errors++;
          $display("Timeout: no done within %0d cycles for %s", DONE_TIMEOUT, what);
          void'(res_q.pop_front());
          void'(nv_q.pop_front());
          void'(nx_q.pop_front());
          void'(lat_q.pop_front());
        end else begin
          lat = int'(cycle - acc) - 1;  // done is seen one edge after it is set
          check_latency(lat, lat_q.pop_front(), what);
          check_result(result, res_q.pop_front(), what);
          check_flags(flag_nv, flag_nx, nv_q.pop_front(), nx_q.pop_front(), what);
        end
      end else if (done) begin
        errors++;
        $display("Error: done pulsed with no operation pending at %0t", $time);
      end
    end
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin : main_seq
    fp_word_t    op;
    fp_word_t    held;
    logic        held_nv;
    logic        held_nx;
    logic [31:0] rnd_e;
    logic [31:0] rnd_f;
    round_mode_t rm;
    clk           = 1'b0;
    reset_n       = 1'b0;
    start         = 1'b0;
    rounding_mode = RNE;
    operand       = '0;
    seed          = 32'hbf9be552;
    cycle         = 0;
    checks        = 0;
    errors        = 0;
    test_base     = 0;

    repeat (2) @(posedge clk);  // Reset held for 2 cycles
    reset_n <= 1'b1;
    @(posedge clk);
    check_status(busy, done, 1'b0, 1'b0, "after reset");
    check_flags(flag_nv, flag_nx, 1'b0, 1'b0, "after reset");
    check_result(result, '0, "after reset");
    finish_test("reset");

    // Exact squares in every mode
    for (int m = 0; m < 5; m++) begin
      rm = round_mode_t'(3'(m));
      issue_op(32'h4080_0000, rm, 32'h4000_0000, 1'b0, 1'b0);  // 4.0 to 2.0
      issue_op(32'h4110_0000, rm, 32'h4040_0000, 1'b0, 1'b0);  // 9.0 to 3.0
      issue_op(32'h3E80_0000, rm, 32'h3F00_0000, 1'b0, 1'b0);  // 0.25 to 0.5
      issue_op(32'h3F80_0000, rm, 32'h3F80_0000, 1'b0, 1'b0);  // 1.0
      issue_op(32'h4210_0000, rm, 32'h40C0_0000, 1'b0, 1'b0);  // 36.0 to 6.0
    end
    finish_test("exact");

    // Special operands
    for (int m = 0; m < 5; m++) begin
      rm = round_mode_t'(3'(m));
      issue_op(32'h7F80_0000, rm, 32'h7F80_0000, 1'b0, 1'b0);  // +inf
      issue_op(32'h0000_0000, rm, 32'h0000_0000, 1'b0, 1'b0);
      issue_op(32'h8000_0000, rm, 32'h8000_0000, 1'b0, 1'b0);  // -0 stays -0
      issue_op(32'h0000_0001, rm, 32'h0000_0000, 1'b0, 1'b0);  // Subnormal flushed
      issue_op(32'h8040_0000, rm, 32'h8000_0000, 1'b0, 1'b0);  // -subnormal gives -0 without flag
      issue_op(32'h7FC0_0000, rm, 32'h7FC0_0000, 1'b0, 1'b0);
      issue_op(32'hFF80_0001, rm, 32'h7FC0_0000, 1'b0, 1'b0);  // Negative sNaN
      issue_op(32'hBF80_0000, rm, 32'h7FC0_0000, 1'b1, 1'b0);  // -1.0
      issue_op(32'hFF80_0000, rm, 32'h7FC0_0000, 1'b1, 1'b0);  // -inf
    end
    finish_test("special");

    // Random positive normals in mode codes 0 to 5 where 5 is undefined
    for (int m = 0; m < 6; m++) begin
      rm = round_mode_t'(3'(m));
      issue_ref(32'h407F_FFFF, rm);  // Just below 4.0
      issue_ref(32'h7F7F_FFFF, rm);  // Largest normal
      issue_ref(32'h0080_0000, rm);  // Smallest normal
      for (int i = 0; i < RANDOM_OPS; i++) begin
        rnd_e = $random(seed);
        rnd_f = $random(seed);
        op    = {1'b0, 8'(32'd1 + rnd_e % 32'd254), rnd_f[22:0]};
        issue_ref(op, rm);
      end
    end
    finish_test("random");

    // Start while busy then result hold
    op   = 32'h4049_0FDB;
    held = expected_sqrt(op, RNE, held_nv, held_nx);
    issue_op(op, RNE, held, held_nv, held_nx);
    repeat (5) @(posedge clk);
    start         <= 1'b1;           // Mid-operation start must be ignored
    operand       <= 32'hBF80_0000;  // -1.0 would give NaN with nv set
    rounding_mode <= RTZ;            // Truncates where RNE rounds up
    @(posedge clk);
    start         <= 1'b0;
    wait_drained();
    repeat (40) @(posedge clk);  // Room for a stray second operation
    check_result(result, held, "held result");
    check_flags(flag_nv, flag_nx, held_nv, held_nx, "held flags");
    check_status(busy, done, 1'b0, 1'b0, "idle after ignored start");
    finish_test("protocol");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
